//--- common/pad_pkg.sv
// Pad counts, attribute layout and default pad variants for the pad frame
// Variant vectors hold 2 bits per pad with pad 0 in the low bits

package pad_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad counts and attribute layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumMio    = 8;
  localparam int NumDio    = 6;
  localparam int AttrDw    = 3;
  localparam int AttrAddrW = 4;   // Covers NumMio + NumDio entries

  localparam int AttrInvertBit = 0;
  localparam int AttrVirtOdBit = 1;
  localparam int AttrInDisBit  = 2;

  // Pad variant codes
  localparam logic [1:0] VarBidir     = 2'd0;
  localparam logic [1:0] VarInput     = 2'd1;
  localparam logic [1:0] VarTolerant  = 2'd2;
  localparam logic [1:0] VarOpenDrain = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // DIO pin map
  ////////////////////////////////////////////////////////////////////////////

  localparam int DioUsbDn     = 0;
  localparam int DioUsbDp     = 1;
  localparam int DioUsbD      = 2;  // Fed by the differential receiver
  localparam int DioUsbPullup = 3;
  localparam int DioSpiSd0    = 4;
  localparam int DioSpiCsb    = 5;

  // Two open drain pads at the top of the MIO bank
  localparam logic [2*NumMio-1:0] MioVariantDefault = {
    VarOpenDrain, VarOpenDrain, {6{VarBidir}}
  };

  localparam logic [2*NumDio-1:0] DioVariantDefault = {
    VarInput,     // CSB
    VarBidir,     // SD0
    VarBidir,     // USB pull-up
    VarBidir,     // USB D
    VarTolerant,  // USB DP
    VarTolerant   // USB DN
  };

  localparam logic [NumMio-1:0] MioConnectDefault = '1;

  // USB D and the pull-up pin are core-side only
  localparam logic [NumDio-1:0] DioConnectDefault =
    ~((NumDio'(1) << DioUsbD) | (NumDio'(1) << DioUsbPullup));

endpackage : pad_pkg

//--- common/pad_core_if.sv
// Core side of one pad bank, one bit of out, oe and in per pad
// attr carries AttrDw bits per pad, pad 0 in the low bits

`timescale 1ns/100ps

interface pad_core_if
  import pad_pkg::*;
#(
  parameter int NumPads = 1
) ();

  logic [NumPads-1:0]             out;
  logic [NumPads-1:0]             oe;
  logic [NumPads-1:0]             in;   // Synchronized, attributes applied
  logic [NumPads-1:0][AttrDw-1:0] attr;

  // Pad bank side
  modport bank (
    input  out, oe, attr,
    output in
  );

  // Core and configuration side
  modport core (
    output out, oe, attr,
    input  in
  );

  modport monitor (
    input out, oe, in, attr
  );

endinterface : pad_core_if

//--- pads/pad_bank.sv
// One bank of modelled pads with separate in, out and oe per pad
// Inputs pass two flops, so the core sees a pad change two cycles later
// Variant and Connect are fixed at elaboration, attributes are live

`timescale 1ns/100ps

module pad_bank
  import pad_pkg::*;
#(
  parameter int                     NumPads = 1,
  parameter logic [2*NumPads-1:0]   Variant = '0,
  parameter logic [NumPads-1:0]     Connect = '1
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NumPads-1:0] pad_in_i,
  output logic [NumPads-1:0] pad_out_o,
  output logic [NumPads-1:0] pad_oe_o,
  pad_core_if.bank           core
);

  ////////////////////////////////////////////////////////////////////////////
  // Input synchronizers
  ////////////////////////////////////////////////////////////////////////////

  logic [NumPads-1:0] sync_q1;
  logic [NumPads-1:0] sync_q2;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-pad drive and input logic
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NumPads; k++) begin : gen_pad
    localparam logic [1:0] PadVar = Variant[2*k +: 2];
    localparam bit         PadCon = Connect[k];

    logic invert;
    logic virt_od;
    logic in_dis;
    logic driven;

    assign invert  = core.attr[k][AttrInvertBit];
    assign virt_od = core.attr[k][AttrVirtOdBit];
    assign in_dis  = core.attr[k][AttrInDisBit];
    assign driven  = core.out[k] ^ invert;

    always_comb begin
      pad_out_o[k] = 1'b0;
      pad_oe_o[k]  = 1'b0;
      if (PadCon) begin
        case (PadVar)
          VarInput: ;  // Never drives
          VarOpenDrain: begin
            pad_oe_o[k] = core.oe[k] & ~driven;  // Pull low only
          end
          VarBidir, VarTolerant: begin
            if (virt_od) begin
              pad_oe_o[k] = core.oe[k] & ~driven;
            end else begin
              pad_out_o[k] = driven;
              pad_oe_o[k]  = core.oe[k];
            end
          end
          default: ;
        endcase
      end
    end

    // Unbonded pads read as zero
    assign core.in[k] = PadCon & ~in_dis & (sync_q2[k] ^ invert);
  end

endmodule : pad_bank

//--- usb/usb_diff_overlay.sv
// Registered USB differential receive value for the USB D input
// Uses the synchronized DP/DN inputs, so a pad change shows 3 cycles later
// Output is zero while the core does not drive the pull-up enable

`timescale 1ns/100ps

module usb_diff_overlay
  import pad_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  output logic        usb_rx_o,
  pad_core_if.monitor dio
);

  logic pullup_en;
  logic diff_valid;
  logic rx_d;
  logic rx_q;

  // Pull-up enable is a driven-high pin on the core side
  assign pullup_en = dio.out[DioUsbPullup] & dio.oe[DioUsbPullup];

  // DP and DN equal is SE0 or SE1, not a valid differential level
  assign diff_valid = dio.in[DioUsbDp] ^ dio.in[DioUsbDn];

  always_comb begin
    rx_d = rx_q;  // Hold last valid level
    if (!pullup_en) begin
      rx_d = 1'b0;
    end else if (diff_valid) begin
      rx_d = dio.in[DioUsbDp];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_q <= 1'b0;
    end else begin
      rx_q <= rx_d;
    end
  end

  assign usb_rx_o = rx_q;

endmodule : usb_diff_overlay

//--- logic/pad_attr_regs.sv
// Pad attribute registers, MIO at addresses 0..NumMio-1, DIO right after
// Writes above the DIO range are dropped and such reads return zero
// Read data is registered, one cycle after the address

`timescale 1ns/100ps

module pad_attr_regs
  import pad_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 attr_we_i,
  input  logic [AttrAddrW-1:0] attr_addr_i,
  input  logic [AttrDw-1:0]    attr_wdata_i,
  output logic [AttrDw-1:0]    attr_rdata_o,
  pad_core_if.core             mio,
  pad_core_if.core             dio
);

  logic [NumMio-1:0][AttrDw-1:0] mio_attr_q;
  logic [NumDio-1:0][AttrDw-1:0] dio_attr_q;
  logic [AttrDw-1:0]             rdata_d;

  ////////////////////////////////////////////////////////////////////////////
  // Attribute storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mio_attr_q <= '0;
      dio_attr_q <= '0;
    end else if (attr_we_i) begin
      for (int i = 0; i < NumMio; i++) begin
        if (attr_addr_i == AttrAddrW'(i)) begin
          mio_attr_q[i] <= attr_wdata_i;
        end
      end
      for (int i = 0; i < NumDio; i++) begin
        if (attr_addr_i == AttrAddrW'(NumMio + i)) begin
          dio_attr_q[i] <= attr_wdata_i;
        end
      end
    end
  end

  assign mio.attr = mio_attr_q;
  assign dio.attr = dio_attr_q;

  ////////////////////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;  // Out of range
    for (int i = 0; i < NumMio; i++) begin
      if (attr_addr_i == AttrAddrW'(i)) begin
        rdata_d = mio_attr_q[i];
      end
    end
    for (int i = 0; i < NumDio; i++) begin
      if (attr_addr_i == AttrAddrW'(NumMio + i)) begin
        rdata_d = dio_attr_q[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      attr_rdata_o <= '0;
    end else begin
      attr_rdata_o <= rdata_d;
    end
  end

endmodule : pad_attr_regs

//--- logic/pad_frame_top.sv
// Pad frame top, core signals to pads are combinational
// Pad inputs reach the core after two cycles, USB D after three
// USB D input always comes from the differential receiver

`timescale 1ns/100ps

module pad_frame_top
  import pad_pkg::*;
#(
  parameter logic [2*NumMio-1:0] MioVariant = MioVariantDefault,
  parameter logic [2*NumDio-1:0] DioVariant = DioVariantDefault,
  parameter logic [NumMio-1:0]   MioConnect = MioConnectDefault,
  parameter logic [NumDio-1:0]   DioConnect = DioConnectDefault
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Muxed IOs
  input  logic [NumMio-1:0]    mio_out_i,
  input  logic [NumMio-1:0]    mio_oe_i,
  input  logic [NumMio-1:0]    mio_pad_in_i,
  output logic [NumMio-1:0]    mio_in_o,
  output logic [NumMio-1:0]    mio_pad_out_o,
  output logic [NumMio-1:0]    mio_pad_oe_o,
  // Dedicated IOs
  input  logic [NumDio-1:0]    dio_out_i,
  input  logic [NumDio-1:0]    dio_oe_i,
  input  logic [NumDio-1:0]    dio_pad_in_i,
  output logic [NumDio-1:0]    dio_in_o,
  output logic [NumDio-1:0]    dio_pad_out_o,
  output logic [NumDio-1:0]    dio_pad_oe_o,
  // Attribute configuration
  input  logic                 attr_we_i,
  input  logic [AttrAddrW-1:0] attr_addr_i,
  input  logic [AttrDw-1:0]    attr_wdata_i,
  output logic [AttrDw-1:0]    attr_rdata_o
);

  pad_core_if #(.NumPads(NumMio)) mio_if ();
  pad_core_if #(.NumPads(NumDio)) dio_if ();

  logic usb_rx;

  assign mio_if.out = mio_out_i;
  assign mio_if.oe  = mio_oe_i;
  assign dio_if.out = dio_out_i;
  assign dio_if.oe  = dio_oe_i;
  assign mio_in_o   = mio_if.in;

  ////////////////////////////////////////////////////////////////////////////
  // Attributes and pad banks
  ////////////////////////////////////////////////////////////////////////////

  pad_attr_regs u_attr_regs (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .attr_we_i    ( attr_we_i    ),
    .attr_addr_i  ( attr_addr_i  ),
    .attr_wdata_i ( attr_wdata_i ),
    .attr_rdata_o ( attr_rdata_o ),
    .mio          ( mio_if       ),
    .dio          ( dio_if       )
  );

  pad_bank #(
    .NumPads ( NumMio     ),
    .Variant ( MioVariant ),
    .Connect ( MioConnect )
  ) u_mio_bank (
    .clk_i     ( clk_i         ),
    .reset_i   ( reset_i       ),
    .pad_in_i  ( mio_pad_in_i  ),
    .pad_out_o ( mio_pad_out_o ),
    .pad_oe_o  ( mio_pad_oe_o  ),
    .core      ( mio_if        )
  );

  pad_bank #(
    .NumPads ( NumDio     ),
    .Variant ( DioVariant ),
    .Connect ( DioConnect )
  ) u_dio_bank (
    .clk_i     ( clk_i         ),
    .reset_i   ( reset_i       ),
    .pad_in_i  ( dio_pad_in_i  ),
    .pad_out_o ( dio_pad_out_o ),
    .pad_oe_o  ( dio_pad_oe_o  ),
    .core      ( dio_if        )
  );

  ////////////////////////////////////////////////////////////////////////////
  // USB overlay
  ////////////////////////////////////////////////////////////////////////////

  usb_diff_overlay u_usb_overlay (
    .clk_i    ( clk_i   ),
    .reset_i  ( reset_i ),
    .usb_rx_o ( usb_rx  ),
    .dio      ( dio_if  )
  );

  for (genvar k = 0; k < NumDio; k++) begin : gen_dio_in
    if (k == DioUsbD) begin : gen_usb_d
      assign dio_in_o[k] = usb_rx;  // Replaces the tied-off pad input
    end else begin : gen_pad_in
      assign dio_in_o[k] = dio_if.in[k];
    end
  end

endmodule : pad_frame_top

//--- test/pad_frame_checker.sv
// Pad drive rules for the default variants and connect masks
// Rules assume the top level keeps its default parameters

`timescale 1ns/100ps

module pad_frame_checker
  import pad_pkg::*;
(
  input logic              clk_i,
  input logic              reset_i,
  input logic [NumMio-1:0] mio_pad_out_i,
  input logic [NumDio-1:0] dio_pad_oe_i,
  input logic [AttrDw-1:0] attr_rdata_i
);

  function automatic logic [NumMio-1:0] open_drain_mask();
    logic [NumMio-1:0] m;
    for (int k = 0; k < NumMio; k++) begin
      m[k] = (MioVariantDefault[2*k +: 2] == VarOpenDrain);
    end
    return m;
  endfunction

  localparam logic [NumMio-1:0] MioOdMask = open_drain_mask();
  localparam logic [NumDio-1:0] DioNoOe   = ~DioConnectDefault | (NumDio'(1) << DioSpiCsb);

  int assert_errors = 0;

  a_dio_no_oe: assert property (@(posedge clk_i) disable iff (reset_i)
    (dio_pad_oe_i & DioNoOe) == '0)
    else begin
      assert_errors++;
      $error("Output enable set on CSB or an unbonded DIO pad");
    end

  a_mio_od_low: assert property (@(posedge clk_i) disable iff (reset_i)
    (mio_pad_out_i & MioOdMask) == '0)
    else begin
      assert_errors++;
      $error("Open drain MIO pad drives high");
    end

  a_rdata_reset: assert property (@(posedge clk_i) reset_i |=> attr_rdata_i == '0)
    else begin
      assert_errors++;
      $error("Attribute read data not zero after reset");
    end

endmodule : pad_frame_checker

bind pad_frame_top pad_frame_checker u_checker (
  .clk_i         ( clk_i         ),
  .reset_i       ( reset_i       ),
  .mio_pad_out_i ( mio_pad_out_o ),
  .dio_pad_oe_i  ( dio_pad_oe_o  ),
  .attr_rdata_i  ( attr_rdata_o  )
);

//--- test/tb_pad_frame.sv
// Random testbench for the pad frame with a cycle model of attributes,
// input synchronizers and the USB overlay. Inputs change on the rising
// edge and outputs are compared at the falling edge.

`timescale 1ns/100ps

module tb_pad_frame
  import pad_pkg::*;
();

  localparam int AddrCycles  = 2**AttrAddrW;  // Every address once
  localparam int RandCycles  = 40;
  localparam int UsbCycles   = 30;            // Per pull-up state
  localparam int TotalCycles = 3 + AddrCycles + 3 * RandCycles + 3 + 2 * UsbCycles;

  logic                 clk;
  logic                 reset;
  logic [NumMio-1:0]    mio_out, mio_oe, mio_pad_in;
  logic [NumMio-1:0]    mio_in, mio_pad_out, mio_pad_oe;
  logic [NumDio-1:0]    dio_out, dio_oe, dio_pad_in;
  logic [NumDio-1:0]    dio_in, dio_pad_out, dio_pad_oe;
  logic                 attr_we;
  logic [AttrAddrW-1:0] attr_addr;
  logic [AttrDw-1:0]    attr_wdata;
  logic [AttrDw-1:0]    attr_rdata;

  // Model state
  logic [AttrDw-1:0] m_attr [2**AttrAddrW];
  logic [AttrDw-1:0] m_rdata;
  logic [NumMio-1:0] m_q1_mio, m_q2_mio;
  logic [NumDio-1:0] m_q1_dio, m_q2_dio;
  logic              m_rx;

  logic [31:0] lfsr = 32'hfda5;
  int          errors, checks, tests, test_errors, test_checks;

  pad_frame_top UUT (
    .clk_i         ( clk         ),
    .reset_i       ( reset       ),
    .mio_out_i     ( mio_out     ),
    .mio_oe_i      ( mio_oe      ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .mio_in_o      ( mio_in      ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_out_i     ( dio_out     ),
    .dio_oe_i      ( dio_oe      ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .dio_in_o      ( dio_in      ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  ),
    .attr_we_i     ( attr_we     ),
    .attr_addr_i   ( attr_addr   ),
    .attr_wdata_i  ( attr_wdata  ),
    .attr_rdata_o  ( attr_rdata  )
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers and reference rules
  ////////////////////////////////////////////////////////////////////////////

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Returns {pad_out, pad_oe}
  function automatic logic [1:0] drive_rule(input logic [1:0] vr, input logic con,
                                            input logic [AttrDw-1:0] a,
                                            input logic o, input logic e);
    logic d;
    d = o ^ a[AttrInvertBit];
    if (!con || vr == VarInput) begin
      return 2'b00;
    end
    if (vr == VarOpenDrain || a[AttrVirtOdBit]) begin
      return {1'b0, e & ~d};
    end
    return {d, e};
  endfunction

  function automatic logic sync_rule(input logic con, input logic [AttrDw-1:0] a,
                                     input logic q);
    return con & ~a[AttrInDisBit] & (q ^ a[AttrInvertBit]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model, checks and reporting
  ////////////////////////////////////////////////////////////////////////////

  // Advance the model with the inputs the DUT sampled at this edge
  task automatic tick();
    logic [NumDio-1:0] din;
    @(posedge clk);
    for (int k = 0; k < NumDio; k++) begin
      din[k] = sync_rule(DioConnectDefault[k], m_attr[NumMio + k], m_q2_dio[k]);
    end
    if (!(dio_out[DioUsbPullup] & dio_oe[DioUsbPullup])) begin
      m_rx = 1'b0;
    end else if (din[DioUsbDp] != din[DioUsbDn]) begin
      m_rx = din[DioUsbDp];
    end
    m_rdata = (attr_addr < NumMio + NumDio) ? m_attr[attr_addr] : '0;
    if (attr_we && attr_addr < NumMio + NumDio) begin
      m_attr[attr_addr] = attr_wdata;
    end
    m_q2_mio = m_q1_mio;
    m_q1_mio = mio_pad_in;
    m_q2_dio = m_q1_dio;
    m_q1_dio = dio_pad_in;
  endtask

  task automatic compare(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("FAILED %s %s: expected 'h%0h, actual 'h%0h", name, what, exp, act);
    end
  endtask

  task automatic check_cycle(input string name);
    logic [NumMio-1:0] e_mout, e_moe, e_min;
    logic [NumDio-1:0] e_dout, e_doe, e_din;
    logic [1:0]        r;
    @(negedge clk);
    for (int k = 0; k < NumMio; k++) begin
      r = drive_rule(MioVariantDefault[2*k +: 2], MioConnectDefault[k], m_attr[k],
                     mio_out[k], mio_oe[k]);
      e_mout[k] = r[1];
      e_moe[k]  = r[0];
      e_min[k]  = sync_rule(MioConnectDefault[k], m_attr[k], m_q2_mio[k]);
    end
    for (int k = 0; k < NumDio; k++) begin
      r = drive_rule(DioVariantDefault[2*k +: 2], DioConnectDefault[k], m_attr[NumMio + k],
                     dio_out[k], dio_oe[k]);
      e_dout[k] = r[1];
      e_doe[k]  = r[0];
      e_din[k]  = sync_rule(DioConnectDefault[k], m_attr[NumMio + k], m_q2_dio[k]);
    end
    e_din[DioUsbD] = m_rx;  // Overlay, not the pad
    compare(name, "mio_pad_out", e_mout, mio_pad_out);
    compare(name, "mio_pad_oe", e_moe, mio_pad_oe);
    compare(name, "mio_in", e_min, mio_in);
    compare(name, "dio_pad_out", e_dout, dio_pad_out);
    compare(name, "dio_pad_oe", e_doe, dio_pad_oe);
    compare(name, "dio_in", e_din, dio_in);
    compare(name, "attr_rdata", m_rdata, attr_rdata);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic drive_core();
    mio_out <= NumMio'(rand_bits(NumMio));
    mio_oe  <= NumMio'(rand_bits(NumMio));
    dio_out <= NumDio'(rand_bits(NumDio));
    dio_oe  <= NumDio'(rand_bits(NumDio));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    mio_out    = '0;
    mio_oe     = '0;
    mio_pad_in = '0;
    dio_out    = '0;
    dio_oe     = '0;
    dio_pad_in = '0;
    attr_we    = 1'b0;
    attr_addr  = '0;
    attr_wdata = '0;
    for (int a = 0; a < 2**AttrAddrW; a++) begin
      m_attr[a] = '0;
    end
    m_rdata  = '0;
    m_q1_mio = '0;
    m_q2_mio = '0;
    m_q1_dio = '0;
    m_q2_dio = '0;
    m_rx     = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    for (int a = 0; a < AddrCycles; a++) begin
      tick();
      attr_addr <= AttrAddrW'(a);
      drive_core();
      check_cycle("reset_state");
    end
    end_test("reset_state");

    // Addresses 14 and 15 are out of range
    for (int i = 0; i < RandCycles; i++) begin
      tick();
      attr_we    <= 1'(rand_bits(1));
      attr_addr  <= AttrAddrW'(rand_bits(AttrAddrW));
      attr_wdata <= AttrDw'(rand_bits(AttrDw));
      check_cycle("attr_rw");
    end
    end_test("attr_rw");

    for (int i = 0; i < RandCycles; i++) begin
      tick();
      attr_we <= 1'b0;
      drive_core();
      check_cycle("pad_drive");
    end
    end_test("pad_drive");

    for (int i = 0; i < RandCycles; i++) begin
      tick();
      mio_pad_in <= NumMio'(rand_bits(NumMio));
      dio_pad_in <= NumDio'(rand_bits(NumDio));
      check_cycle("pad_input");
    end
    end_test("pad_input");

    // Plain DP and DN inputs, then pull-up on and off
    for (int i = 0; i < 3; i++) begin
      tick();
      attr_we    <= (i < 2);
      attr_addr  <= AttrAddrW'(NumMio + ((i == 0) ? DioUsbDn : DioUsbDp));
      attr_wdata <= '0;
      check_cycle("usb_overlay");
    end
    for (int i = 0; i < 2 * UsbCycles; i++) begin
      tick();
      drive_core();
      dio_out[DioUsbPullup] <= (i < UsbCycles);
      dio_oe[DioUsbPullup]  <= 1'b1;
      dio_pad_in <= NumDio'(rand_bits(NumDio));
      check_cycle("usb_overlay");
    end
    end_test("usb_overlay");

    errors += UUT.u_checker.assert_errors;
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TotalCycles + 50) * 10);
    $display("Timeout: the tests did not complete within %0d cycles", TotalCycles + 50);
    $display("Finished with errors");
    $finish;
  end

endmodule : tb_pad_frame

//--- src.f
common/pad_pkg.sv
common/pad_core_if.sv
pads/pad_bank.sv
usb/usb_diff_overlay.sv
logic/pad_attr_regs.sv
logic/pad_frame_top.sv
test/pad_frame_checker.sv
test/tb_pad_frame.sv

//--- Bender.yml
package:
  name: pad_frame

sources:
  - common/pad_pkg.sv
  - common/pad_core_if.sv
  - pads/pad_bank.sv
  - usb/usb_diff_overlay.sv
  - logic/pad_attr_regs.sv
  - logic/pad_frame_top.sv
  - target: test
    files:
      - test/pad_frame_checker.sv
      - test/tb_pad_frame.sv
